// ==== Bender.yml ====
package:
  name: pacman_video

sources:
  - include_dirs:
      - .
    files:
      - pacPkg.sv
      - videoTiming.sv
      - keyDecoder.sv
      - pelletStore.sv
      - regBank.sv
      - playfieldRenderer.sv
      - pacmanTop.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbPacman.sv

// ==== all.f ====
+incdir+.
pacPkg.sv
videoTiming.sv
keyDecoder.sv
pelletStore.sv
regBank.sv
playfieldRenderer.sv
pacmanTop.sv
tbPacman.sv

// ==== keyDecoder.sv ====
module keyDecoder (
  input  logic        clk,
  input  logic        rst,
  input  logic [7:0]  keycode,
  output pacPkg::rotT dir,
  output logic        keystrobe
);

  logic        hit;
  pacPkg::rotT newDir;

  always_comb begin
    hit    = 1'b0;
    newDir = dir;
    if (keycode[7]) begin  // only codes with bit 7 are key events
      hit = 1'b1;
      case (keycode)
        8'hf7:   newDir = pacPkg::rotUp;
        8'hf3:   newDir = pacPkg::rotDown;
        8'he1:   newDir = pacPkg::rotLeft;
        8'he4:   newDir = pacPkg::rotRight;
        default: hit = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dir       <= pacPkg::rotLeft;
      keystrobe <= 1'b0;
    end else begin
      keystrobe <= hit;  // repeats while the code is held
      if (hit) dir <= newDir;
    end
  end

endmodule

// ==== pacDefs.svh ====
`ifndef PAC_DEFS_SVH
`define PAC_DEFS_SVH

// 640x480 horizontal timing, in pixels
`define H_VISIBLE    640
`define H_SYNC_START 656
`define H_SYNC_END   751
`define H_TOTAL      800

// vertical timing, in lines
`define V_VISIBLE    480
`define V_SYNC_START 490
`define V_SYNC_END   491
`define V_TOTAL      525

`define PLAY_WIDTH 448  // right edge of the maze
`define CELL_SHIFT 4    // 16x16 pixel cells

// pellet dot inside a cell
`define DOT_LO 6
`define DOT_HI 9

`define PELLET_X_MIN 1
`define PELLET_X_MAX 27
`define PELLET_Y_MIN 1
`define PELLET_Y_MAX 28

// power-up corners
`define POWER_X_A 2
`define POWER_X_B 27
`define POWER_Y_A 4
`define POWER_Y_B 24

`endif

// ==== pacPkg.sv ====
package pacPkg;

  typedef enum logic [1:0] {
    rotUp    = 2'd0,
    rotLeft  = 2'd1,
    rotDown  = 2'd2,
    rotRight = 2'd3
  } rotT;

  typedef enum logic [3:0] {
    cBlack  = 4'd0,
    cBlue   = 4'd1,
    cYellow = 4'd6,
    cWhite  = 4'd7
  } colorT;

  // host register map, same addresses as the game cpu used
  typedef enum logic [5:0] {
    aPacX        = 6'd0,
    aPacY        = 6'd1,
    aFrameSync   = 6'd36,
    aPelletX     = 6'd37,
    aPelletY     = 6'd38,
    aPelletClear = 6'd39,
    aPlayerRot   = 6'd49,
    aPelletData  = 6'd51
  } regAddrT;

  typedef struct packed {
    logic [9:0] hpos;
    logic [9:0] vpos;
    logic       hsync;       // active low
    logic       vsync;       // active low
    logic       frameStart;
  } videoPosT;

  typedef struct packed {
    logic [5:0]  addr;
    logic [15:0] wrData;
    logic        we;
  } hostBusT;

  typedef struct packed {
    logic [4:0] pacX;
    logic [4:0] pacY;
    logic [4:0] pelletX;
    logic [4:0] pelletY;
  } spriteRegsT;

  typedef struct packed {
    logic [4:0] x;
    logic [4:0] y;
  } cellT;

endpackage

// ==== pacmanTop.sv ====
module pacmanTop (
  input  logic            clk,
  input  logic            rst,
  input  logic [7:0]      keycode,
  input  pacPkg::hostBusT host,
  output logic [15:0]     rdData,
  output logic            hsync,
  output logic            vsync,
  output pacPkg::colorT   rgb,
  output logic            keystrobe
);

  pacPkg::videoPosT   pos;
  pacPkg::spriteRegsT sprite;
  pacPkg::cellT       renderCell;
  pacPkg::rotT        dir;
  logic               renderDot;
  logic               pelletClear;
  logic [1:0]         pelletData;

  videoTiming timing (
    .clk (clk),
    .rst (rst),
    .pos (pos)
  );

  keyDecoder keys (
    .clk       (clk),
    .rst       (rst),
    .keycode   (keycode),
    .dir       (dir),
    .keystrobe (keystrobe)
  );

  pelletStore pellets (
    .clk         (clk),
    .rst         (rst),
    .renderCell  (renderCell),
    .renderDot   (renderDot),
    .sprite      (sprite),
    .pelletClear (pelletClear),
    .pelletData  (pelletData)
  );

  regBank regs (
    .clk         (clk),
    .rst         (rst),
    .host        (host),
    .rdData      (rdData),
    .frameStart  (pos.frameStart),
    .dir         (dir),
    .pelletData  (pelletData),
    .sprite      (sprite),
    .pelletClear (pelletClear)
  );

  playfieldRenderer renderer (
    .clk        (clk),
    .rst        (rst),
    .pos        (pos),
    .sprite     (sprite),
    .renderCell (renderCell),
    .renderDot  (renderDot),
    .hsync      (hsync),
    .vsync      (vsync),
    .rgb        (rgb)
  );

endmodule

// ==== pelletStore.sv ====
`include "pacDefs.svh"

module pelletStore (
  input  logic               clk,
  input  logic               rst,
  input  pacPkg::cellT       renderCell,
  output logic               renderDot,
  input  pacPkg::spriteRegsT sprite,
  input  logic               pelletClear,
  output logic [1:0]         pelletData
);

  logic [31:0]  bitmap [32];  // indexed [y][x]
  pacPkg::cellT hostCell;
  logic         hostPresent;
  logic         corner;

  function automatic logic hasPellet(input pacPkg::cellT c);
    logic inRange;
    inRange = c.x >= `PELLET_X_MIN && c.x <= `PELLET_X_MAX &&
              c.y >= `PELLET_Y_MIN && c.y <= `PELLET_Y_MAX;
    return inRange && bitmap[c.y][c.x];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      bitmap <= '{default: '1};  // fresh maze, every cell full
    end else if (pelletClear) begin
      bitmap[sprite.pelletY][sprite.pelletX] <= 1'b0;
    end
  end

  assign hostCell = '{x: sprite.pelletX, y: sprite.pelletY};

  assign corner = (hostCell.x == `POWER_X_A || hostCell.x == `POWER_X_B) &&
                  (hostCell.y == `POWER_Y_A || hostCell.y == `POWER_Y_B);

  always_comb begin
    renderDot   = hasPellet(renderCell);
    hostPresent = hasPellet(hostCell);
  end

  assign pelletData = {hostPresent && corner, hostPresent};  // {power-up, present}

  // the host side must stay quiet until the bitmap has been refilled
  noClearInReset: assert property (@(posedge clk) rst |-> !pelletClear);

endmodule

// ==== playfieldRenderer.sv ====
`include "pacDefs.svh"

module playfieldRenderer (
  input  logic               clk,
  input  logic               rst,
  input  pacPkg::videoPosT   pos,
  input  pacPkg::spriteRegsT sprite,
  output pacPkg::cellT       renderCell,
  input  logic               renderDot,
  output logic               hsync,
  output logic               vsync,
  output pacPkg::colorT      rgb
);

  logic [4:0]    cellX;
  logic [4:0]    cellY;
  logic [3:0]    offX;
  logic [3:0]    offY;
  logic          visible;
  logic          inPlay;
  logic          wall;
  logic          dotArea;
  pacPkg::colorT color;

  assign cellX = 5'(pos.hpos >> `CELL_SHIFT);
  assign cellY = 5'(pos.vpos >> `CELL_SHIFT);
  assign offX  = pos.hpos[`CELL_SHIFT-1:0];
  assign offY  = pos.vpos[`CELL_SHIFT-1:0];

  assign renderCell = '{x: cellX, y: cellY};

  assign visible = pos.hpos < `H_VISIBLE && pos.vpos < `V_VISIBLE;
  assign inPlay  = visible && pos.hpos < `PLAY_WIDTH;

  // border walls: left column, top row and the last row on screen
  assign wall = cellX == '0 || cellY == '0 ||
                cellY == 5'((`V_VISIBLE >> `CELL_SHIFT) - 1);

  assign dotArea = offX >= `DOT_LO && offX <= `DOT_HI &&
                   offY >= `DOT_LO && offY <= `DOT_HI;

  always_comb begin
    color = pacPkg::cBlack;
    if (inPlay) begin
      if (cellX == sprite.pacX && cellY == sprite.pacY) color = pacPkg::cYellow;
      else if (wall)                                    color = pacPkg::cBlue;
      else if (renderDot && dotArea)                    color = pacPkg::cWhite;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      rgb   <= pacPkg::cBlack;
    end else begin
      hsync <= pos.hsync;  // keep syncs aligned with the colour
      vsync <= pos.vsync;
      rgb   <= color;
    end
  end

endmodule

// ==== regBank.sv ====
module regBank (
  input  logic               clk,
  input  logic               rst,
  input  pacPkg::hostBusT    host,
  output logic [15:0]        rdData,
  input  logic               frameStart,
  input  pacPkg::rotT        dir,
  input  logic [1:0]         pelletData,
  output pacPkg::spriteRegsT sprite,
  output logic               pelletClear
);

  pacPkg::regAddrT    addr;
  pacPkg::spriteRegsT spr;
  logic               frameSync;
  logic [15:0]        rdMux;

  assign addr = pacPkg::regAddrT'(host.addr);

  // clear strobe acts on the cell held in pelletX/pelletY
  assign pelletClear = host.we && addr == pacPkg::aPelletClear && host.wrData[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      spr       <= '0;
      frameSync <= 1'b0;
    end else begin
      if (host.we) begin
        case (addr)
          pacPkg::aPacX:      spr.pacX    <= host.wrData[4:0];
          pacPkg::aPacY:      spr.pacY    <= host.wrData[4:0];
          pacPkg::aPelletX:   spr.pelletX <= host.wrData[4:0];
          pacPkg::aPelletY:   spr.pelletY <= host.wrData[4:0];
          pacPkg::aFrameSync: frameSync   <= host.wrData[0];
          default: ;  // read-only or unmapped
        endcase
      end
      if (frameStart) frameSync <= 1'b1;  // beats a same-cycle host clear
    end
  end

  always_comb begin
    rdMux = '0;
    case (addr)
      pacPkg::aPacX:       rdMux = 16'(spr.pacX);
      pacPkg::aPacY:       rdMux = 16'(spr.pacY);
      pacPkg::aPelletX:    rdMux = 16'(spr.pelletX);
      pacPkg::aPelletY:    rdMux = 16'(spr.pelletY);
      pacPkg::aFrameSync:  rdMux = 16'(frameSync);
      pacPkg::aPlayerRot:  rdMux = 16'(dir);
      pacPkg::aPelletData: rdMux = 16'(pelletData);
      default:             rdMux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) rdData <= '0;
    else     rdData <= rdMux;
  end

  assign sprite = spr;

  // the flag only drops on a host clear that misses the frame start
  frameFlagClear: assert property (@(posedge clk) disable iff (rst)
    $fell(frameSync) |-> $past(host.we && addr == pacPkg::aFrameSync &&
                               !host.wrData[0] && !frameStart));

endmodule

// ==== tbPacman.sv ====
`include "pacDefs.svh"

module tbPacman;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int frameCycles = `H_TOTAL * `V_TOTAL;

  logic            clk;
  logic            rst;
  logic [7:0]      keycode;
  pacPkg::hostBusT host;
  logic [15:0]     rdData;
  logic            hsync;
  logic            vsync;
  pacPkg::colorT   rgb;
  logic            keystrobe;

  integer      seed;
  int          mh;  // model beam position as held before the next edge
  int          mv;
  logic [4:0]  mPacX;
  logic [4:0]  mPacY;
  logic [4:0]  mPelX;
  logic [4:0]  mPelY;
  logic        mFlag;
  logic [1:0]  mDir;
  logic [31:0] mPel [32];  // [y][x]

  pacmanTop DUT (
    .clk       (clk),
    .rst       (rst),
    .keycode   (keycode),
    .host      (host),
    .rdData    (rdData),
    .hsync     (hsync),
    .vsync     (vsync),
    .rgb       (rgb),
    .keystrobe (keystrobe)
  );

  always #50 clk = ~clk;

  function automatic int rnd(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic pelletAt(input int x, input int y);
    if (x < `PELLET_X_MIN || x > `PELLET_X_MAX) return 1'b0;
    if (y < `PELLET_Y_MIN || y > `PELLET_Y_MAX) return 1'b0;
    return mPel[y][x];
  endfunction

  function automatic logic [15:0] modelRead(input logic [5:0] a);
    logic present;
    logic corner;
    present = pelletAt(mPelX, mPelY);
    corner  = (mPelX == `POWER_X_A || mPelX == `POWER_X_B) &&
              (mPelY == `POWER_Y_A || mPelY == `POWER_Y_B);
    case (a)
      pacPkg::aPacX:       return 16'(mPacX);
      pacPkg::aPacY:       return 16'(mPacY);
      pacPkg::aPelletX:    return 16'(mPelX);
      pacPkg::aPelletY:    return 16'(mPelY);
      pacPkg::aFrameSync:  return 16'(mFlag);
      pacPkg::aPlayerRot:  return 16'(mDir);
      pacPkg::aPelletData: return {14'd0, present && corner, present};
      default:             return 16'd0;
    endcase
  endfunction

  function automatic logic [3:0] modelColor(input int h, input int v);
    int cx;
    int cy;
    int ox;
    int oy;
    cx = h / 16;
    cy = v / 16;
    ox = h % 16;
    oy = v % 16;
    if (h >= `PLAY_WIDTH || v >= `V_VISIBLE) return pacPkg::cBlack;
    if (cx == mPacX && cy == mPacY) return pacPkg::cYellow;
    if (cx == 0 || cy == 0 || cy == 29) return pacPkg::cBlue;  // border walls
    if (pelletAt(cx, cy) && ox >= `DOT_LO && ox <= `DOT_HI &&
        oy >= `DOT_LO && oy <= `DOT_HI) return pacPkg::cWhite;
    return pacPkg::cBlack;
  endfunction

  // {hit, new direction}
  function automatic logic [2:0] decodeKey(input logic [7:0] code);
    case (code)
      8'hf7:   return {1'b1, 2'(pacPkg::rotUp)};
      8'hf3:   return {1'b1, 2'(pacPkg::rotDown)};
      8'he1:   return {1'b1, 2'(pacPkg::rotLeft)};
      8'he4:   return {1'b1, 2'(pacPkg::rotRight)};
      default: return {1'b0, mDir};
    endcase
  endfunction

  function automatic logic [5:0] addrOf(input int i);
    case (i)
      0:       return pacPkg::aPacX;
      1:       return pacPkg::aPacY;
      2:       return pacPkg::aFrameSync;
      3:       return pacPkg::aPelletX;
      4:       return pacPkg::aPelletY;
      5:       return pacPkg::aPelletClear;
      6:       return pacPkg::aPlayerRot;
      default: return pacPkg::aPelletData;
    endcase
  endfunction

  task automatic abortRun();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abortRun();
    end
  endtask

  task automatic modelReset();
    mh    = 0;
    mv    = 0;
    mPacX = '0;
    mPacY = '0;
    mPelX = '0;
    mPelY = '0;
    mFlag = 1'b0;
    mDir  = 2'(pacPkg::rotLeft);
    foreach (mPel[i]) mPel[i] = '1;
  endtask

  // predict from the state before the edge, check, then advance the model
  task automatic tick();
    logic [15:0] expRd;
    logic [3:0]  expRgb;
    logic        expHs;
    logic        expVs;
    logic [2:0]  key;
    expRd  = modelRead(host.addr);
    expRgb = modelColor(mh, mv);
    expHs  = !(mh >= `H_SYNC_START && mh <= `H_SYNC_END);
    expVs  = !(mv >= `V_SYNC_START && mv <= `V_SYNC_END);
    key    = decodeKey(keycode);
    @(negedge clk);
    checkVal("hsync", hsync, expHs);
    checkVal("vsync", vsync, expVs);
    checkVal("rgb", rgb, expRgb);
    checkVal("keystrobe", keystrobe, key[2]);
    checkVal("rdData", rdData, expRd);
    if (host.we && host.addr == pacPkg::aPelletClear && host.wrData[0])
      mPel[mPelY][mPelX] = 1'b0;  // uses the pellet cell before this write
    if (host.we) begin
      case (host.addr)
        pacPkg::aPacX:      mPacX = host.wrData[4:0];
        pacPkg::aPacY:      mPacY = host.wrData[4:0];
        pacPkg::aPelletX:   mPelX = host.wrData[4:0];
        pacPkg::aPelletY:   mPelY = host.wrData[4:0];
        pacPkg::aFrameSync: mFlag = host.wrData[0];
        default: ;
      endcase
    end
    if (mh == 0 && mv == 0) mFlag = 1'b1;  // frame start wins
    mDir = key[1:0];
    mh = mh + 1;
    if (mh == `H_TOTAL) begin
      mh = 0;
      mv = (mv + 1) % `V_TOTAL;
    end
  endtask

  // wrPermille sets how often a cycle carries a write
  task automatic randomStim(input int wrPermille);
    logic [15:0] data;
    logic [5:0]  addr;
    data = 16'($random(seed));
    addr = rnd(10) < 8 ? addrOf(rnd(8)) : 6'(rnd(64));
    if (addr == pacPkg::aPelletX && rnd(2) == 0)
      data[4:0] = rnd(2) ? 5'(`POWER_X_A) : 5'(`POWER_X_B);  // aim at the corners
    if (addr == pacPkg::aPelletY && rnd(2) == 0)
      data[4:0] = rnd(2) ? 5'(`POWER_Y_A) : 5'(`POWER_Y_B);
    host.addr   = addr;
    host.wrData = data;
    host.we     = rnd(1000) < wrPermille;
    if (rnd(4) == 0) keycode = rnd(2) ? 8'hf7 : 8'hf3;
    else if (rnd(3) == 0) keycode = rnd(2) ? 8'he1 : 8'he4;
    else keycode = 8'($random(seed));
  endtask

  task automatic waitFrameStart();
    int n;
    n = 0;
    while (!(mh == 0 && mv == 0)) begin
      if (n > frameCycles + 10) begin
        $display("timeout while waiting for the start of a frame");
        abortRun();
      end
      randomStim(2);
      tick();
      n++;
    end
  endtask

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    host    = '0;
    keycode = 8'h00;
    seed    = 32'hd775_4cbd;
    modelReset();
    repeat (4) @(negedge clk);
    rst = 1'b0;
    checkVal("hsync", hsync, 1'b1);
    checkVal("vsync", vsync, 1'b1);
    checkVal("rgb", rgb, pacPkg::cBlack);
    checkVal("keystrobe", keystrobe, 1'b0);
    checkVal("rdData", rdData, 16'd0);

    repeat (4000) begin  // busy register, pellet and key traffic
      randomStim(500);
      tick();
    end

    waitFrameStart();
    keycode = 8'h00;
    host = '{addr: pacPkg::aFrameSync, wrData: 16'h0000, we: 1'b1};  // clear meets frame start
    tick();
    host.we = 1'b0;
    tick();
    checkVal("rdData", rdData, 16'd1);
    host.we = 1'b1;  // plain clear away from frame start
    tick();
    host.we = 1'b0;
    tick();
    checkVal("rdData", rdData, 16'd0);

    repeat (frameCycles + 1000) begin  // whole frame of syncs and pixels
      randomStim(2);
      tick();
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== videoTiming.sv ====
`include "pacDefs.svh"

module videoTiming (
  input  logic             clk,
  input  logic             rst,
  output pacPkg::videoPosT pos
);

  logic [9:0] hCnt;
  logic [9:0] vCnt;
  logic       hEnd;
  logic       vEnd;

  assign hEnd = hCnt == 10'(`H_TOTAL - 1);
  assign vEnd = vCnt == 10'(`V_TOTAL - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      hCnt <= '0;
      vCnt <= '0;
    end else if (hEnd) begin
      hCnt <= '0;
      vCnt <= vEnd ? '0 : vCnt + 10'd1;  // next line, or back to the top
    end else begin
      hCnt <= hCnt + 10'd1;
    end
  end

  assign pos.hpos = hCnt;
  assign pos.vpos = vCnt;

  // sync levels straight from the counters, the renderer delays them
  assign pos.hsync = !(hCnt >= `H_SYNC_START && hCnt <= `H_SYNC_END);
  assign pos.vsync = !(vCnt >= `V_SYNC_START && vCnt <= `V_SYNC_END);

  assign pos.frameStart = hCnt == '0 && vCnt == '0;

  // horizontal counter never runs past the end of a line
  hposInRange: assert property (@(posedge clk) disable iff (rst)
    pos.hpos < `H_TOTAL);

endmodule
